/* compile.f */
hw/scratchPkg.sv
hw/byteColumnRam.sv
hw/tdpRamBe.sv
hw/hostPort.sv
hw/rrArbiter.sv
hw/copyEngine.sv
hw/scratchMemTop.sv
testbench/scratchMem_assertions.sv
testbench/scratchMemTb.sv

/* hw/byteColumnRam.sv */
// Byte-wide dual-port RAM column
`timescale 1ns/1ps

module byteColumnRam #(
   parameter int ADDR_WIDTH = 8
) (
   input  logic                  clk,

   // Port A
   input  logic                  enA,
   input  logic                  weA,
   input  logic [ADDR_WIDTH-1:0] addrA,
   input  logic [7:0]            dinA,
   output logic [7:0]            doutA,

   // Port B
   input  logic                  enB,
   input  logic                  weB,
   input  logic [ADDR_WIDTH-1:0] addrB,
   input  logic [7:0]            dinB,
   output logic [7:0]            doutB
);

   logic [7:0] mem [2**ADDR_WIDTH];

   // Read-first on both ports, output holds while disabled
   // Same-address collisions between ports are left undefined
   always_ff @(posedge clk) begin
      if (enA) begin
         doutA <= mem[addrA];  // Old word
         if (weA) begin
            mem[addrA] <= dinA;
         end
      end
      if (enB) begin
         doutB <= mem[addrB];
         if (weB) begin
            mem[addrB] <= dinB;
         end
      end
   end

endmodule

/* hw/copyEngine.sv */
// Block copy engine on RAM port B
`timescale 1ns/1ps

module copyEngine (
   input  logic                           clk,
   input  logic                           rstN,

   // Copy control
   input  logic                           copyStart,
   input  logic [scratchPkg::ADDR_W-1:0]  copySrc,
   input  logic [scratchPkg::ADDR_W-1:0]  copyDst,
   input  logic [scratchPkg::ADDR_W:0]    copyLen,  // In words
   output logic                           copyBusy,
   output logic                           copyDone,

   // RAM port B
   output logic                           enB,
   output logic [scratchPkg::BYTES_W-1:0] weB,
   output logic [scratchPkg::ADDR_W-1:0]  addrB,
   output logic [scratchPkg::DATA_W-1:0]  dinB,
   input  logic [scratchPkg::DATA_W-1:0]  doutB
);

   localparam logic [scratchPkg::ADDR_W-1:0] ADDR_ONE = 1;
   localparam logic [scratchPkg::ADDR_W:0]   LEN_ONE  = 1;

   scratchPkg::copyState           state;
   logic                           startQ;
   logic                           accept;
   logic [scratchPkg::ADDR_W-1:0]  srcPtr;
   logic [scratchPkg::ADDR_W-1:0]  dstPtr;
   logic [scratchPkg::ADDR_W:0]    remaining;  // Words still to move

   assign copyBusy = startQ
                  || (state == scratchPkg::COPY_READ)
                  || (state == scratchPkg::COPY_WRITE);
   assign copyDone = (state == scratchPkg::COPY_DONE);
   assign accept   = copyStart && !copyBusy;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         startQ <= 1'b0;
         state  <= scratchPkg::COPY_IDLE;
      end else begin
         startQ <= accept;  // One-cycle pulse, busy blocks a second start
         case (state)
            scratchPkg::COPY_IDLE: begin
               if (startQ) begin
                  state <= (remaining == '0) ? scratchPkg::COPY_DONE
                                             : scratchPkg::COPY_READ;
               end
            end
            scratchPkg::COPY_READ: begin
               state <= scratchPkg::COPY_WRITE;
            end
            scratchPkg::COPY_WRITE: begin
               state <= (remaining == LEN_ONE) ? scratchPkg::COPY_DONE
                                               : scratchPkg::COPY_READ;
            end
            default: begin
               state <= scratchPkg::COPY_IDLE;  // After the done pulse
            end
         endcase
      end
   end

   // Pointers advance once per copied word
   always_ff @(posedge clk) begin
      if (accept) begin
         srcPtr    <= copySrc;
         dstPtr    <= copyDst;
         remaining <= copyLen;
      end else if (state == scratchPkg::COPY_WRITE) begin
         srcPtr    <= srcPtr + ADDR_ONE;
         dstPtr    <= dstPtr + ADDR_ONE;
         remaining <= remaining - LEN_ONE;
      end
   end

   // Read word lands on doutB in the write cycle and goes straight back in
   always_comb begin
      enB   = 1'b0;
      weB   = '0;
      addrB = srcPtr;
      dinB  = doutB;
      case (state)
         scratchPkg::COPY_READ: begin
            enB = 1'b1;
         end
         scratchPkg::COPY_WRITE: begin
            enB   = 1'b1;
            weB   = '1;     // Whole word
            addrB = dstPtr;
         end
         default: begin
            enB = 1'b0;
         end
      endcase
   end

endmodule

/* hw/hostPort.sv */
// Host port request holder
`timescale 1ns/1ps

module hostPort (
   input  logic                          clk,
   input  logic                          rstN,

   // Host side
   input  logic                          reqValid,
   input  scratchPkg::memReq             req,
   output logic                          busy,
   output logic                          done,
   output logic [scratchPkg::DATA_W-1:0] rdData,

   // Arbiter and RAM side
   output logic                          pending,
   output scratchPkg::memReq             heldReq,
   input  logic                          grant,
   input  logic [scratchPkg::DATA_W-1:0] ramRdData
);

   logic                          accept;
   logic                          rdNow;
   logic [scratchPkg::DATA_W-1:0] rdHold;

   assign accept = reqValid && !pending;  // Strobes while busy are dropped

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pending <= 1'b0;
         done    <= 1'b0;
      end else begin
         done <= pending && grant;  // RAM access happens at this edge
         if (pending && grant) begin
            pending <= 1'b0;
         end else if (accept) begin
            pending <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         heldReq <= req;
      end
   end

   // Busy covers waiting and the granted cycle, it drops as done pulses
   assign busy = pending;

   // Port A output is only ours during the done cycle, so keep a copy
   assign rdNow = done && (heldReq.op == scratchPkg::OP_READ);

   always_ff @(posedge clk) begin
      if (rdNow) begin
         rdHold <= ramRdData;
      end
   end

   assign rdData = rdNow ? ramRdData : rdHold;

endmodule

/* hw/rrArbiter.sv */
// Round-robin arbiter for RAM port A
`timescale 1ns/1ps

module rrArbiter (
   input  logic                           clk,
   input  logic                           rstN,

   input  logic [1:0]                     pending,
   input  scratchPkg::memReq              reqIn0,
   input  scratchPkg::memReq              reqIn1,
   output logic [1:0]                     grant,

   // RAM port A
   output logic                           enA,
   output logic [scratchPkg::BYTES_W-1:0] weA,
   output logic [scratchPkg::ADDR_W-1:0]  addrA,
   output logic [scratchPkg::DATA_W-1:0]  dinA
);

   logic              lastWin;  // Winner of the last contested cycle
   scratchPkg::memReq sel;

   // Under contention the port that lost last time goes first
   assign grant[0] = pending[0] && (!pending[1] || lastWin);
   assign grant[1] = pending[1] && (!pending[0] || !lastWin);

   always_ff @(posedge clk) begin
      if (!rstN) begin
         lastWin <= 1'b1;  // Host 0 first after reset
      end else if (pending[0] && pending[1]) begin
         lastWin <= grant[1];
      end
   end

   assign sel = grant[1] ? reqIn1 : reqIn0;

   assign enA   = grant[0] || grant[1];
   assign weA   = (sel.op == scratchPkg::OP_WRITE) ? sel.byteEn : '0;
   assign addrA = sel.addr;
   assign dinA  = sel.wrData;

endmodule

/* hw/scratchMemTop.sv */
// Shared scratchpad memory top level
`timescale 1ns/1ps

module scratchMemTop (
   input  logic                          clk,
   input  logic                          rstN,

   // Host 0
   input  logic                          reqValid0,
   input  scratchPkg::memReq             req0,
   output logic                          busy0,
   output logic                          done0,
   output logic [scratchPkg::DATA_W-1:0] rdData0,

   // Host 1
   input  logic                          reqValid1,
   input  scratchPkg::memReq             req1,
   output logic                          busy1,
   output logic                          done1,
   output logic [scratchPkg::DATA_W-1:0] rdData1,

   // Copy engine control
   input  logic                          copyStart,
   input  logic [scratchPkg::ADDR_W-1:0] copySrc,
   input  logic [scratchPkg::ADDR_W-1:0] copyDst,
   input  logic [scratchPkg::ADDR_W:0]   copyLen,
   output logic                          copyBusy,
   output logic                          copyDone
);

   logic [1:0]                     pending;
   logic [1:0]                     grant;
   scratchPkg::memReq              heldReq0;
   scratchPkg::memReq              heldReq1;

   logic                           enA;
   logic [scratchPkg::BYTES_W-1:0] weA;
   logic [scratchPkg::ADDR_W-1:0]  addrA;
   logic [scratchPkg::DATA_W-1:0]  dinA;
   logic [scratchPkg::DATA_W-1:0]  doutA;  // Shared by both hosts

   logic                           enB;
   logic [scratchPkg::BYTES_W-1:0] weB;
   logic [scratchPkg::ADDR_W-1:0]  addrB;
   logic [scratchPkg::DATA_W-1:0]  dinB;
   logic [scratchPkg::DATA_W-1:0]  doutB;

   hostPort iHostPort0 (
      .clk       (clk),
      .rstN      (rstN),
      .reqValid  (reqValid0),
      .req       (req0),
      .busy      (busy0),
      .done      (done0),
      .rdData    (rdData0),
      .pending   (pending[0]),
      .heldReq   (heldReq0),
      .grant     (grant[0]),
      .ramRdData (doutA)
   );

   hostPort iHostPort1 (
      .clk       (clk),
      .rstN      (rstN),
      .reqValid  (reqValid1),
      .req       (req1),
      .busy      (busy1),
      .done      (done1),
      .rdData    (rdData1),
      .pending   (pending[1]),
      .heldReq   (heldReq1),
      .grant     (grant[1]),
      .ramRdData (doutA)
   );

   rrArbiter iArbiter (
      .clk     (clk),
      .rstN    (rstN),
      .pending (pending),
      .reqIn0  (heldReq0),
      .reqIn1  (heldReq1),
      .grant   (grant),
      .enA     (enA),
      .weA     (weA),
      .addrA   (addrA),
      .dinA    (dinA)
   );

   copyEngine iCopyEngine (
      .clk       (clk),
      .rstN      (rstN),
      .copyStart (copyStart),
      .copySrc   (copySrc),
      .copyDst   (copyDst),
      .copyLen   (copyLen),
      .copyBusy  (copyBusy),
      .copyDone  (copyDone),
      .enB       (enB),
      .weB       (weB),
      .addrB     (addrB),
      .dinB      (dinB),
      .doutB     (doutB)
   );

   tdpRamBe #(
      .ADDR_WIDTH (scratchPkg::ADDR_W),
      .DATA_WIDTH (scratchPkg::DATA_W)
   ) iRam (
      .clk   (clk),
      .enA   (enA),
      .weA   (weA),
      .addrA (addrA),
      .dinA  (dinA),
      .doutA (doutA),
      .enB   (enB),
      .weB   (weB),
      .addrB (addrB),
      .dinB  (dinB),
      .doutB (doutB)
   );

endmodule

/* hw/scratchPkg.sv */
// Scratchpad memory shared types
// Widths, request struct and state encodings

package scratchPkg;

   // Memory geometry
   localparam int ADDR_W  = 8;          // 256 words
   localparam int DATA_W  = 32;
   localparam int BYTES_W = DATA_W / 8; // One write enable per lane

   // Host operation
   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } memOp;

   // One memory operation as issued by a host, 45 bits
   typedef struct packed {
      memOp               op;
      logic [BYTES_W-1:0] byteEn;  // Ignored on reads
      logic [ADDR_W-1:0]  addr;
      logic [DATA_W-1:0]  wrData;
   } memReq;

   // Copy engine FSM
   typedef enum logic [1:0] {
      COPY_IDLE  = 2'd0,
      COPY_READ  = 2'd1,
      COPY_WRITE = 2'd2,
      COPY_DONE  = 2'd3
   } copyState;

endpackage

/* hw/tdpRamBe.sv */
// Dual-port RAM with byte write enables
`timescale 1ns/1ps

module tdpRamBe #(
   parameter int ADDR_WIDTH = 8,
   parameter int DATA_WIDTH = 32
) (
   input  logic                    clk,

   // Port A
   input  logic                    enA,
   input  logic [DATA_WIDTH/8-1:0] weA,
   input  logic [ADDR_WIDTH-1:0]   addrA,
   input  logic [DATA_WIDTH-1:0]   dinA,
   output logic [DATA_WIDTH-1:0]   doutA,

   // Port B
   input  logic                    enB,
   input  logic [DATA_WIDTH/8-1:0] weB,
   input  logic [ADDR_WIDTH-1:0]   addrB,
   input  logic [DATA_WIDTH-1:0]   dinB,
   output logic [DATA_WIDTH-1:0]   doutB
);

   localparam int COL_W   = 8;
   localparam int NUM_COL = DATA_WIDTH / COL_W;

   // One column per byte lane, each with its own write enable
   for (genvar lane = 0; lane < NUM_COL; lane++) begin : gCol
      byteColumnRam #(
         .ADDR_WIDTH (ADDR_WIDTH)
      ) iCol (
         .clk   (clk),
         .enA   (enA),
         .weA   (weA[lane]),
         .addrA (addrA),
         .dinA  (dinA[lane*COL_W +: COL_W]),
         .doutA (doutA[lane*COL_W +: COL_W]),
         .enB   (enB),
         .weB   (weB[lane]),
         .addrB (addrB),
         .dinB  (dinB[lane*COL_W +: COL_W]),
         .doutB (doutB[lane*COL_W +: COL_W])
      );
   end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the scratchpad memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
   -f compile.f \
   --top-module scratchMemTb \
   --Mdir "$BUILD_DIR" \
   -o scratchMemSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/scratchMemSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "TESTS PASSED" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* testbench/scratchMemTb.sv */
// Scratchpad memory testbench
`timescale 1ns/1ps

module scratchMemTb;

   localparam int NUM_FILL    = 256;
   localparam int NUM_RANDOM  = 100;  // Write plus readback each
   localparam int NUM_PAIRS   = 16;
   localparam int NUM_IGNORED = 4;
   localparam int NUM_COPIES  = 8;
   localparam int MAX_LEN     = 32;
   // Up to 4 cycles per host op and 2 per copied word plus start and done
   localparam int MAX_CYCLES = 4 * (NUM_FILL + 2 * NUM_RANDOM + 2 * NUM_PAIRS
                                    + 2 * NUM_IGNORED + (NUM_COPIES + 1) * (MAX_LEN + 1))
                             + (NUM_COPIES + 1) * (2 * MAX_LEN + 4) + 500;

   logic                          clk;
   logic                          rstN;
   logic [1:0]                    reqValid;
   scratchPkg::memReq             req [2];
   logic [1:0]                    busy;
   logic [1:0]                    done;
   logic [scratchPkg::DATA_W-1:0] rdData [2];
   logic                          copyStart;
   logic [scratchPkg::ADDR_W-1:0] copySrc;
   logic [scratchPkg::ADDR_W-1:0] copyDst;
   logic [scratchPkg::ADDR_W:0]   copyLen;
   logic                          copyBusy;
   logic                          copyDone;

   logic [31:0] model [256];  // Reference memory
   logic [31:0] expRd [2];    // Model word when the request went out
   int          doneAt [2];   // Cycles from strobe to done
   int          seed;
   int          errors;
   int          checks;
   int          issueCycle;
   int          lateExp;      // Port expected to lose the next contested cycle
   int          cycleCnt = 0;

   scratchMemTop i_scratchMemTop (
      .clk       (clk),
      .rstN      (rstN),
      .reqValid0 (reqValid[0]),
      .req0      (req[0]),
      .busy0     (busy[0]),
      .done0     (done[0]),
      .rdData0   (rdData[0]),
      .reqValid1 (reqValid[1]),
      .req1      (req[1]),
      .busy1     (busy[1]),
      .done1     (done[1]),
      .rdData1   (rdData[1]),
      .copyStart (copyStart),
      .copySrc   (copySrc),
      .copyDst   (copyDst),
      .copyLen   (copyLen),
      .copyBusy  (copyBusy),
      .copyDone  (copyDone)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      cycleCnt <= cycleCnt + 1;
      if (cycleCnt >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, a done pulse never came", cycleCnt);
         $display("TESTS FAILED");
         $finish;
      end
   end

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   function automatic logic [31:0] nextRand();
      return $random(seed);
   endfunction

   function automatic scratchPkg::memReq makeReq(logic write, logic [3:0] be,
                                                 logic [7:0] addr, logic [31:0] data);
      scratchPkg::memReq r;
      r.op     = write ? scratchPkg::OP_WRITE : scratchPkg::OP_READ;
      r.byteEn = be;
      r.addr   = addr;
      r.wrData = data;
      return r;
   endfunction

   // Host 0 owns words 0-63 and host 1 owns 64-127
   function automatic scratchPkg::memReq randReq(int port, logic write, logic fullWord);
      logic [31:0] rnd;
      rnd = nextRand();
      return makeReq(write, fullWord ? 4'hf : rnd[11:8], {1'b0, port[0], rnd[5:0]},
                     nextRand());
   endfunction

   function automatic void modelWrite(scratchPkg::memReq r);
      for (int b = 0; b < 4; b++) begin
         if (r.byteEn[b]) begin
            model[r.addr][8*b +: 8] = r.wrData[8*b +: 8];
         end
      end
   endfunction

   // One strobe cycle on the selected ports with the model updated at issue
   task automatic issue(input logic [1:0] which, input scratchPkg::memReq r0,
                        input scratchPkg::memReq r1);
      @(posedge clk);
      #1;
      reqValid   = which;
      req[0]     = r0;
      req[1]     = r1;
      issueCycle = cycleCnt;
      expRd[0]   = model[r0.addr];
      expRd[1]   = model[r1.addr];
      if (which[0] && r0.op == scratchPkg::OP_WRITE) begin
         modelWrite(r0);
      end
      if (which[1] && r1.op == scratchPkg::OP_WRITE) begin
         modelWrite(r1);
      end
      @(posedge clk);
      #1;
      reqValid = 2'b00;
   endtask

   task automatic waitDone(input logic [1:0] which);
      logic [1:0] seen;
      seen = ~which;
      while (seen != 2'b11) begin
         @(negedge clk);
         if (done[0] && !seen[0]) begin
            seen[0]   = 1'b1;
            doneAt[0] = cycleCnt - issueCycle;
         end
         if (done[1] && !seen[1]) begin
            seen[1]   = 1'b1;
            doneAt[1] = cycleCnt - issueCycle;
         end
      end
   endtask

   task automatic hostOp(input int port, input scratchPkg::memReq r, input string name);
      issue((port == 0) ? 2'b01 : 2'b10, r, r);
      waitDone((port == 0) ? 2'b01 : 2'b10);
      check({name, " latency"}, 2, doneAt[port]);
      check({name, " busy at done"}, 32'd0, {31'd0, busy[port]});  // Falls with done
      if (r.op == scratchPkg::OP_READ) begin
         check({name, " rdData"}, expRd[port], rdData[port]);
      end
   endtask

   task automatic contendPair(input scratchPkg::memReq r0, input scratchPkg::memReq r1);
      issue(2'b11, r0, r1);
      check("contention busy", 32'd3, {30'd0, busy});  // Both held
      waitDone(2'b11);
      check("contention winner latency", 2, doneAt[1 - lateExp]);
      check("contention loser latency", 3, doneAt[lateExp]);
      if (r0.op == scratchPkg::OP_READ) begin
         check("contention rdData0", expRd[0], rdData[0]);
      end
      if (r1.op == scratchPkg::OP_READ) begin
         check("contention rdData1", expRd[1], rdData[1]);
      end
      lateExp = 1 - lateExp;
   endtask

   // Second strobe lands while host 0 is busy and must vanish
   task automatic ignoredStrobe(input scratchPkg::memReq r, input scratchPkg::memReq extra);
      issue(2'b01, r, r);
      check("busy after strobe", 32'd1, {31'd0, busy[0]});
      reqValid = 2'b01;
      req[0]   = extra;
      @(posedge clk);
      #1;
      reqValid = 2'b00;
      waitDone(2'b01);
      check("latency with ignored strobe", 2, doneAt[0]);
      check("rdData with ignored strobe", expRd[0], rdData[0]);
      repeat (4) begin
         @(negedge clk);
         check("no done for ignored strobe", 32'd0, {31'd0, done[0]});
      end
   endtask

   task automatic runCopy(input int src, input int dst, input int len);
      int startAt;
      @(posedge clk);
      #1;
      copyStart = 1'b1;
      copySrc   = 8'(src);
      copyDst   = 8'(dst);
      copyLen   = 9'(len);
      startAt   = cycleCnt;
      for (int i = 0; i < len; i++) begin
         model[8'(dst + i)] = model[8'(src + i)];
      end
      @(posedge clk);
      #1;
      check("copy busy after start", 32'd1, {31'd0, copyBusy});
      copyDst = 8'(src);  // Start still held while busy is ignored
      @(posedge clk);
      #1;
      copyStart = 1'b0;
      while (!copyDone) begin
         @(negedge clk);
      end
      check("copy latency", 2 * len + 2, cycleCnt - startAt);
      check("copy busy at done", 32'd0, {31'd0, copyBusy});
      for (int i = 0; i <= len; i++) begin
         hostOp(1, makeReq(1'b0, 4'h0, 8'(dst + i), 32'd0), "copy readback");
      end
   endtask

   initial begin
      logic [31:0] rnd;
      int          port;
      int          len;
      scratchPkg::memReq w;
      seed      = 32'hf1ae_69b9;
      errors    = 0;
      checks    = 0;
      lateExp   = 1;  // Host 0 wins the first contested cycle
      rstN      = 1'b0;
      reqValid  = 2'b00;
      req[0]    = '0;
      req[1]    = '0;
      copyStart = 1'b0;
      copySrc   = '0;
      copyDst   = '0;
      copyLen   = '0;
      repeat (16) @(posedge clk);
      #1;
      rstN = 1'b1;

      // Known contents everywhere first
      for (int a = 0; a < NUM_FILL; a++) begin
         hostOp(a / 128, makeReq(1'b1, 4'hf, 8'(a), nextRand()), "fill");
      end

      for (int n = 0; n < NUM_RANDOM; n++) begin
         rnd  = nextRand();
         port = int'(rnd[0]);
         w    = randReq(port, 1'b1, rnd[1]);
         hostOp(port, w, "random write");
         hostOp(port, makeReq(1'b0, 4'h0, w.addr, 32'd0),
                rnd[1] ? "full-word readback" : "byte-enable readback");
      end

      for (int n = 0; n < NUM_PAIRS; n++) begin
         rnd = nextRand();
         contendPair(randReq(0, rnd[0], rnd[1]), randReq(1, rnd[2], rnd[3]));
      end

      for (int n = 0; n < NUM_IGNORED; n++) begin
         w = randReq(0, 1'b0, 1'b1);
         ignoredStrobe(w, makeReq(1'b1, 4'hf, w.addr, ~model[w.addr]));
         hostOp(0, w, "readback after ignored strobe");
      end

      // Source in 128-191, destination in 192-255 with a word past its end
      for (int n = 0; n < NUM_COPIES; n++) begin
         rnd = nextRand();
         len = 1 + int'(rnd[4:0]);
         runCopy(128 + int'(rnd[13:8]) % (65 - len), 192 + int'(rnd[21:16]) % (64 - len), len);
      end
      runCopy(140, 200, 0);

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

/* testbench/scratchMem_assertions.sv */
// Bound checks on arbiter, host ports and copy engine
`timescale 1ns/1ps

module scratchMemAssertions (
   input logic                 clk,
   input logic                 rstN,
   input logic [1:0]           grant,
   input logic                 done0,
   input logic                 done1,
   input logic                 enB,
   input logic                 copyBusy,
   input logic                 copyDone,
   input scratchPkg::copyState state
);

   oneGrant: assert property (@(posedge clk) disable iff (!rstN)
      !(grant[0] && grant[1]))
      else $error("Port A granted to both hosts in one cycle");

   // Done exactly one cycle after each grant, and never without one
   done0AfterGrant: assert property (@(posedge clk) disable iff (!rstN)
      grant[0] |=> done0)
      else $error("Host 0 done missing after grant");
   done0NeedsGrant: assert property (@(posedge clk) disable iff (!rstN)
      done0 |-> $past(grant[0]))
      else $error("Host 0 done without a grant");
   done1AfterGrant: assert property (@(posedge clk) disable iff (!rstN)
      grant[1] |=> done1)
      else $error("Host 1 done missing after grant");
   done1NeedsGrant: assert property (@(posedge clk) disable iff (!rstN)
      done1 |-> $past(grant[1]))
      else $error("Host 1 done without a grant");

   idleNoPortB: assert property (@(posedge clk) disable iff (!rstN)
      (state == scratchPkg::COPY_IDLE) |-> !enB)
      else $error("Port B enabled while copy engine idle");

   // Busy drops in the done cycle itself
   doneEndsBusy: assert property (@(posedge clk) disable iff (!rstN)
      $rose(copyDone) |-> $past(copyBusy))
      else $error("Copy done without a copy in progress");

endmodule

bind scratchMemTop scratchMemAssertions iAssertions (
   .clk      (clk),
   .rstN     (rstN),
   .grant    (grant),
   .done0    (done0),
   .done1    (done1),
   .enB      (enB),
   .copyBusy (copyBusy),
   .copyDone (copyDone),
   .state    (iCopyEngine.state)
);
